/* source/frv_pkg.sv */
`default_nettype none

package frv_pkg;

    // ------------------------------------------------------------
    // Widths and plain vector types
    // ------------------------------------------------------------

    localparam int XLEN = 32;                       // Fixed, PC paths are 32 bit

    typedef logic [XLEN-1:0] xlen_t;                // Data word
    typedef logic [31:0]     addr_t;                // Program counter
    typedef logic [4:0]      reg_idx_t;             // GPR index
    typedef logic [11:0]     csr_addr_t;            // CSR address
    typedef logic [4:0]      uop_t;                 // Micro-op code

    // ------------------------------------------------------------
    // Functional units and micro-ops
    // ------------------------------------------------------------

    typedef enum logic [2:0] {
        FU_ALU = 3'd0,
        FU_MUL = 3'd1,
        FU_LSU = 3'd2,
        FU_CFU = 3'd3,
        FU_CSR = 3'd4
    } fu_e;

    // CFU codes are whole values of uop
    localparam uop_t CFU_TAKEN     = 5'd1;          // Branch taken
    localparam uop_t CFU_NOT_TAKEN = 5'd2;          // Branch falls through
    localparam uop_t CFU_JALI      = 5'd3;          // JAL
    localparam uop_t CFU_JALR      = 5'd4;          // JALR
    localparam uop_t CFU_MRET      = 5'd5;          // Return from trap
    localparam uop_t CFU_ECALL     = 5'd6;
    localparam uop_t CFU_EBREAK    = 5'd7;

    // LSU and CSR codes are bit positions within uop
    localparam int LSU_LOAD  = 3;                   // Set for loads, clear for stores

    localparam int CSR_READ  = 4;                   // Result goes to rd
    localparam int CSR_WRITE = 3;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 1;

    // ------------------------------------------------------------
    // Machine CSRs and trap causes
    // ------------------------------------------------------------

    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    localparam xlen_t CAUSE_BREAKPOINT = 32'd3;
    localparam xlen_t CAUSE_ECALL_M    = 32'd11;
    localparam xlen_t CAUSE_EXTERNAL   = 32'h8000_000b; // Interrupt bit set

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------

    typedef struct packed {
        reg_idx_t rd;                               // Destination register
        xlen_t    opr_a;                            // Result or target
        xlen_t    opr_b;                            // CSR address in low bits
        addr_t    pc;                               // PC of this item
        addr_t    next_pc;                          // Link value for JAL/JALR
        uop_t     uop;
        fu_e      fu;
        logic     trap;                             // Raised upstream
        logic [31:0] instr;                         // Instruction word
    } s4_item_t;

    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xlen_t    wdata;
    } gpr_wr_t;

    typedef struct packed {
        logic      en;                              // Access this cycle
        logic      wr;
        logic      set;
        logic      clr;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic  trap;
        logic  mret;
        xlen_t cause;
        addr_t epc;
    } csr_event_t;

    typedef struct packed {
        logic        valid;
        addr_t       pc;
        logic [31:0] instr;
    } trace_t;

endpackage

`default_nettype wire

/* source/frv_gpr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module frv_gpr_file (
    input  logic                g_clk,
    input  logic                g_resetn,

    input  frv_pkg::gpr_wr_t    gpr_wr,         // Single write port
    input  frv_pkg::reg_idx_t   rd_idx,         // Readback index
    output frv_pkg::xlen_t      rd_data
);

    frv_pkg::xlen_t regs [1:31];                // x0 not stored

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wr.wen && gpr_wr.rd != '0) begin
            regs[gpr_wr.rd] <= gpr_wr.wdata;    // x0 writes dropped
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    always_comb begin
        if (rd_idx == '0) begin
            rd_data = '0;                       // Hardwired zero
        end else begin
            rd_data = regs[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* source/frv_csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module frv_csr_file #(
    parameter frv_pkg::xlen_t MTVEC_RESET = 32'h0000_0000
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,

    input  frv_pkg::csr_req_t    csr_req,
    output frv_pkg::xlen_t       csr_rdata,     // Combinational read

    input  frv_pkg::csr_event_t  csr_evt,
    input  logic                 cf_ack,        // Redirect accepted

    output frv_pkg::xlen_t       mtvec,         // Trap vector
    output frv_pkg::xlen_t       mepc           // Return address
);

    frv_pkg::xlen_t mtvec_q, mepc_q, mcause_q, mscratch_q;
    frv_pkg::xlen_t wr_value;                   // New value of addressed CSR
    logic           csr_write;                  // Any modifying access

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------

    always_comb begin
        case (csr_req.addr)
            frv_pkg::CSR_MTVEC:    csr_rdata = mtvec_q;
            frv_pkg::CSR_MEPC:     csr_rdata = mepc_q;
            frv_pkg::CSR_MCAUSE:   csr_rdata = mcause_q;
            frv_pkg::CSR_MSCRATCH: csr_rdata = mscratch_q;
            default:               csr_rdata = '0;      // Unimplemented
        endcase
    end

    // Write, set and clear all work from the current value
    always_comb begin
        if (csr_req.wr) begin
            wr_value = csr_req.wdata;
        end else if (csr_req.set) begin
            wr_value = csr_rdata | csr_req.wdata;
        end else begin
            wr_value = csr_rdata & ~csr_req.wdata;      // Clear
        end
    end

    assign csr_write = csr_req.en && (csr_req.wr || csr_req.set || csr_req.clr);

    // ------------------------------------------------------------
    // Update
    // ------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (csr_evt.trap && cf_ack) begin
            mepc_q   <= csr_evt.epc;                    // Capture on redirect
            mcause_q <= csr_evt.cause;
        end else if (csr_evt.mret && cf_ack) begin
            mcause_q <= '0;                             // Handler left
        end else if (csr_write) begin
            case (csr_req.addr)
                frv_pkg::CSR_MTVEC:    mtvec_q    <= wr_value;
                frv_pkg::CSR_MEPC:     mepc_q     <= wr_value;
                frv_pkg::CSR_MCAUSE:   mcause_q   <= wr_value;
                frv_pkg::CSR_MSCRATCH: mscratch_q <= wr_value;
                default: ;                              // Writes ignored
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/frv_pc_redirect.sv */
`timescale 1ns/100ps
`default_nettype none

module frv_pc_redirect #(
    parameter frv_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic            g_clk,
    input  logic            g_resetn,

    input  logic            cf_req,             // From writeback
    input  frv_pkg::addr_t  cf_target,
    output logic            cf_ack,             // One cycle pulse

    output frv_pkg::addr_t  pc                  // Fetch PC
);

    logic pending;                              // Request seen last cycle

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------

    // Ack in the cycle after the request first appears
    assign cf_ack = pending;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pending <= 1'b0;
        end else begin
            pending <= cf_req && !pending;      // Drops on the ack edge
        end
    end

    // ------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= RESET_PC;
        end else if (cf_ack) begin
            pc <= cf_target;                    // Redirect on ack edge
        end
    end

endmodule

`default_nettype wire

/* source/frv_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module frv_writeback (
    input  logic                 g_clk,
    input  logic                 g_resetn,

    input  frv_pkg::s4_item_t    s4_item,       // Stage 4 item
    input  logic                 s4_valid,      // Item present
    output logic                 s4_busy,       // Stall upstream

    output frv_pkg::gpr_wr_t     gpr_wr,        // To register file

    output frv_pkg::csr_req_t    csr_req,       // CSR access
    input  frv_pkg::xlen_t       csr_rdata,     // Old CSR value
    output frv_pkg::csr_event_t  csr_evt,       // Trap / MRET effects
    input  frv_pkg::xlen_t       csr_mtvec,
    input  frv_pkg::xlen_t       csr_mepc,

    output logic                 cf_req,        // Redirect request
    output frv_pkg::addr_t       cf_target,
    input  logic                 cf_ack,

    output frv_pkg::trace_t      trace
);

    logic pipe_progress;                        // Item retires this cycle

    assign pipe_progress = s4_valid && !s4_busy;

    // ------------------------------------------------------------
    // Functional unit decode
    // ------------------------------------------------------------

    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;

    always_comb begin
        fu_alu = 1'b0;
        fu_mul = 1'b0;
        fu_lsu = 1'b0;
        fu_cfu = 1'b0;
        fu_csr = 1'b0;
        case (s4_item.fu)
            frv_pkg::FU_ALU: fu_alu = 1'b1;
            frv_pkg::FU_MUL: fu_mul = 1'b1;
            frv_pkg::FU_LSU: fu_lsu = 1'b1;
            frv_pkg::FU_CFU: fu_cfu = 1'b1;
            frv_pkg::FU_CSR: fu_csr = 1'b1;
            default: ;                          // Unknown unit does nothing
        endcase
    end

    // ------------------------------------------------------------
    // Control flow
    // ------------------------------------------------------------

    logic cfu_taken;                            // Branch or jump to opr_a
    logic cfu_link;                             // JAL/JALR write next_pc
    logic cfu_ecall, cfu_ebreak, cfu_mret;
    logic take_trap;                            // Any trap, goes to mtvec
    logic cf_needed;                            // Item must redirect fetch
    logic cfu_finish_now;                       // Acknowledged this cycle
    logic cfu_done;                             // Acked, pipe not yet moved

    assign cfu_taken  = fu_cfu && (s4_item.uop == frv_pkg::CFU_TAKEN ||
                                   s4_item.uop == frv_pkg::CFU_JALI  ||
                                   s4_item.uop == frv_pkg::CFU_JALR);
    assign cfu_link   = fu_cfu && (s4_item.uop == frv_pkg::CFU_JALI ||
                                   s4_item.uop == frv_pkg::CFU_JALR);
    assign cfu_ecall  = fu_cfu && s4_item.uop == frv_pkg::CFU_ECALL;
    assign cfu_ebreak = fu_cfu && s4_item.uop == frv_pkg::CFU_EBREAK;
    assign cfu_mret   = fu_cfu && s4_item.uop == frv_pkg::CFU_MRET;

    assign take_trap  = s4_item.trap || cfu_ecall || cfu_ebreak;

    assign cf_needed  = s4_valid && (cfu_taken || cfu_mret || take_trap);
    assign cf_req     = cf_needed && !cfu_done;         // Not again once acked
    assign cfu_finish_now = cf_req && cf_ack;

    assign s4_busy    = cf_needed && !(cfu_done || cfu_finish_now);

    always_comb begin
        if (take_trap) begin
            cf_target = csr_mtvec;              // Trap wins over everything
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = s4_item.opr_a;          // Branch / jump target
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || cfu_finish_now);
        end
    end

    // Trap event, taken by the CSR file on the ack edge
    assign csr_evt.trap  = s4_valid && take_trap;
    assign csr_evt.mret  = s4_valid && cfu_mret && !s4_item.trap;
    assign csr_evt.epc   = s4_item.pc;              // Faulting item
    assign csr_evt.cause = s4_item.trap ? frv_pkg::CAUSE_EXTERNAL   :
                           cfu_ebreak   ? frv_pkg::CAUSE_BREAKPOINT :
                                          frv_pkg::CAUSE_ECALL_M;

    // ------------------------------------------------------------
    // CSR access
    // ------------------------------------------------------------

    logic csr_ok;                               // Live, untrapped CSR item

    assign csr_ok        = s4_valid && fu_csr && !s4_item.trap;
    assign csr_req.en    = csr_ok;
    assign csr_req.wr    = csr_ok && s4_item.uop[frv_pkg::CSR_WRITE];
    assign csr_req.set   = csr_ok && s4_item.uop[frv_pkg::CSR_SET];
    assign csr_req.clr   = csr_ok && s4_item.uop[frv_pkg::CSR_CLEAR];
    assign csr_req.addr  = s4_item.opr_b[11:0];
    assign csr_req.wdata = s4_item.opr_a;

    // ------------------------------------------------------------
    // GPR writeback
    // ------------------------------------------------------------

    logic alu_wen, lsu_wen, csr_wen, cfu_wen;

    assign alu_wen = fu_alu || fu_mul;                          // Result in opr_a
    assign lsu_wen = fu_lsu && s4_item.uop[frv_pkg::LSU_LOAD];  // Stores write nothing
    assign csr_wen = fu_csr && s4_item.uop[frv_pkg::CSR_READ];
    assign cfu_wen = cfu_link;

    assign gpr_wr.wen = pipe_progress && !take_trap &&
                        (alu_wen || lsu_wen || csr_wen || cfu_wen);
    assign gpr_wr.rd  = s4_item.rd;

    always_comb begin
        if (csr_wen) begin
            gpr_wr.wdata = csr_rdata;           // Old CSR value
        end else if (cfu_wen) begin
            gpr_wr.wdata = s4_item.next_pc;     // Return address
        end else begin
            gpr_wr.wdata = s4_item.opr_a;       // ALU, MUL, load data
        end
    end

    // ------------------------------------------------------------
    // Trace
    // ------------------------------------------------------------

    assign trace.valid = pipe_progress;         // One pulse per retired item
    assign trace.pc    = s4_item.pc;
    assign trace.instr = s4_item.instr;

endmodule

`default_nettype wire

/* source/frv_wb_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module frv_wb_subsystem #(
    parameter frv_pkg::addr_t RESET_PC    = 32'h0000_0000,
    parameter frv_pkg::xlen_t MTVEC_RESET = 32'h0000_0000
) (
    input  logic                g_clk,
    input  logic                g_resetn,

    input  frv_pkg::s4_item_t   s4_item,
    input  logic                s4_valid,
    output logic                s4_busy,

    output frv_pkg::gpr_wr_t    gpr_wr,         // Commit view
    output frv_pkg::trace_t     trace,
    output frv_pkg::addr_t      pc,

    input  frv_pkg::reg_idx_t   rd_idx,         // Register readback
    output frv_pkg::xlen_t      rd_data
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------

    frv_pkg::csr_req_t   csr_req;
    frv_pkg::xlen_t      csr_rdata;
    frv_pkg::csr_event_t csr_evt;
    frv_pkg::xlen_t      csr_mtvec, csr_mepc;
    logic                cf_req, cf_ack;
    frv_pkg::addr_t      cf_target;

    frv_writeback u_writeback (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s4_item   (s4_item),
        .s4_valid  (s4_valid),
        .s4_busy   (s4_busy),
        .gpr_wr    (gpr_wr),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .csr_evt   (csr_evt),
        .csr_mtvec (csr_mtvec),
        .csr_mepc  (csr_mepc),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack),
        .trace     (trace)
    );

    frv_csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .csr_evt   (csr_evt),
        .cf_ack    (cf_ack),
        .mtvec     (csr_mtvec),
        .mepc      (csr_mepc)
    );

    frv_gpr_file u_gpr (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .gpr_wr   (gpr_wr),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    frv_pc_redirect #(
        .RESET_PC (RESET_PC)
    ) u_redirect (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack),
        .pc        (pc)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic g_clk,                         // 100 ns period
    output logic g_resetn                       // Active low, synchronous
);

    // ------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------

    initial begin
        g_clk = 1'b0;
        forever begin
            #50 g_clk = ~g_clk;                 // Half period
        end
    end

    // ------------------------------------------------------------
    // Reset, held for 4 rising edges
    // ------------------------------------------------------------

    initial begin
        g_resetn = 1'b0;
        repeat (4) @(posedge g_clk);
        g_resetn <= 1'b1;                       // Released on an edge
    end

endmodule

`default_nettype wire

/* tb/wb_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_asserts (
    input logic           g_clk,
    input logic           g_resetn,
    input logic           s4_valid,
    input logic           s4_busy,
    input logic           cf_req,
    input logic           cf_ack,
    input frv_pkg::addr_t cf_target
);

    int fail_count = 0;                         // Read by tb_top at the end

    // ------------------------------------------------------------
    // Redirect handshake
    // ------------------------------------------------------------

    // Request and target hold until the ack
    req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target))
        else begin
            $error("cf_req dropped or cf_target moved before cf_ack");
            fail_count++;
        end

    ack_with_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_ack |-> cf_req)
        else begin
            $error("cf_ack seen without cf_req");
            fail_count++;
        end

    // ------------------------------------------------------------
    // Stage handshake
    // ------------------------------------------------------------

    busy_with_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_busy |-> s4_valid)
        else begin
            $error("s4_busy high with no item present");
            fail_count++;
        end

endmodule

bind frv_writeback wb_asserts u_wb_asserts (.*);

`default_nettype wire

/* tb/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam frv_pkg::addr_t RESET_PC    = 32'h0000_0100;
    localparam frv_pkg::xlen_t MTVEC_RESET = 32'h0000_0080;

    logic                g_clk, g_resetn;
    frv_pkg::s4_item_t   s4_item;
    logic                s4_valid, s4_busy;
    frv_pkg::gpr_wr_t    gpr_wr;
    frv_pkg::trace_t     trace;
    frv_pkg::addr_t      pc;
    frv_pkg::reg_idx_t   rd_idx;
    frv_pkg::xlen_t      rd_data;

    // Golden vectors, one entry per file line
    logic [63:0]         kind_q[$];             // Tag, up to 8 chars
    frv_pkg::s4_item_t   item_q[$];
    logic                exp_wen_q[$];
    frv_pkg::xlen_t      exp_wdata_q[$];
    frv_pkg::addr_t      exp_pc_q[$];           // pc after retire
    frv_pkg::reg_idx_t   rb_idx_q[$];
    frv_pkg::xlen_t      rb_val_q[$];

    logic                loaded;                // Starts the watchdog
    int                  cur_item;

    tb_clock u_clock (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    frv_wb_subsystem #(
        .RESET_PC    (RESET_PC),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_frv_wb_subsystem (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .s4_item  (s4_item),
        .s4_valid (s4_valid),
        .s4_busy  (s4_busy),
        .gpr_wr   (gpr_wr),
        .trace    (trace),
        .pc       (pc),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    // ------------------------------------------------------------
    // Error reporting
    // ------------------------------------------------------------

    task automatic fail_run(input string reason);
        $display("ERROR: %0s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("MISMATCH %0s expected %08h got %08h (item %0d, %0s)",
                 sig, exp, got, cur_item, kind_q[cur_item]);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // ------------------------------------------------------------
    // Golden file
    // ------------------------------------------------------------

    task automatic load_golden();
        int                fd;
        int                n;
        string             line;
        logic [63:0]       kind;
        logic [31:0]       f_rd, f_a, f_b, f_pc, f_npc, f_uop, f_fu, f_trap, f_instr;
        logic [31:0]       f_wen, f_wdata, f_epc, f_rbi, f_rbv;
        frv_pkg::s4_item_t it;
        fd = $fopen("tb/wb_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tb/wb_golden.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;   // Blank or comment
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        kind, f_rd, f_a, f_b, f_pc, f_npc, f_uop, f_fu, f_trap,
                        f_instr, f_wen, f_wdata, f_epc, f_rbi, f_rbv);
            if (n != 15) begin
                fail_run("malformed line in golden file");
            end
            it.rd      = f_rd[4:0];
            it.opr_a   = f_a;
            it.opr_b   = f_b;
            it.pc      = f_pc;
            it.next_pc = f_npc;
            it.uop     = f_uop[4:0];
            it.fu      = frv_pkg::fu_e'(f_fu[2:0]);
            it.trap    = f_trap[0];
            it.instr   = f_instr;
            kind_q.push_back(kind);
            item_q.push_back(it);
            exp_wen_q.push_back(f_wen[0]);
            exp_wdata_q.push_back(f_wdata);
            exp_pc_q.push_back(f_epc);
            rb_idx_q.push_back(f_rbi[4:0]);
            rb_val_q.push_back(f_rbv);
        end
        $fclose(fd);
        if (item_q.size() == 0) begin
            fail_run("golden file holds no items");
        end
    endtask

    // Redirecting items stall one cycle, all others none
    function automatic int expected_stalls(input frv_pkg::s4_item_t it);
        logic jumps;
        jumps = it.fu == frv_pkg::FU_CFU && it.uop != frv_pkg::CFU_NOT_TAKEN;
        return (it.trap || jumps) ? 1 : 0;
    endfunction

    // ------------------------------------------------------------
    // One item through the stage
    // ------------------------------------------------------------

    task automatic run_item(input int idx);
        frv_pkg::s4_item_t it;
        int                stalls;
        it       = item_q[idx];
        stalls   = 0;
        cur_item = idx;
        @(posedge g_clk);
        s4_item  <= it;
        s4_valid <= 1'b1;
        @(negedge g_clk);
        while (s4_busy) begin                   // Watchdog bounds this
            assert (!trace.valid) else fail_run("trace.valid pulsed while stalled");
            stalls++;
            @(negedge g_clk);
        end
        // Retire cycle
        assert (trace.valid) else report_mismatch("trace.valid", 32'd1, 32'd0);
        assert (trace.pc == it.pc) else report_mismatch("trace.pc", it.pc, trace.pc);
        assert (trace.instr == it.instr)
            else report_mismatch("trace.instr", it.instr, trace.instr);
        assert (gpr_wr.wen == exp_wen_q[idx])
            else report_mismatch("gpr_wr.wen", {31'b0, exp_wen_q[idx]}, {31'b0, gpr_wr.wen});
        if (exp_wen_q[idx]) begin
            assert (gpr_wr.rd == it.rd)
                else report_mismatch("gpr_wr.rd", {27'b0, it.rd}, {27'b0, gpr_wr.rd});
            assert (gpr_wr.wdata == exp_wdata_q[idx])
                else report_mismatch("gpr_wr.wdata", exp_wdata_q[idx], gpr_wr.wdata);
        end
        @(posedge g_clk);
        s4_valid <= 1'b0;
        rd_idx   <= rb_idx_q[idx];              // Readback after the write edge
        @(negedge g_clk);
        assert (!trace.valid) else fail_run("trace.valid longer than one cycle");
        assert (stalls == expected_stalls(it))
            else report_mismatch("s4_busy cycles", expected_stalls(it), stalls);
        assert (pc == exp_pc_q[idx]) else report_mismatch("pc", exp_pc_q[idx], pc);
        assert (rd_data == rb_val_q[idx])
            else report_mismatch("rd_data", rb_val_q[idx], rd_data);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        s4_item   = '0;
        s4_valid  = 1'b0;
        rd_idx    = '0;
        loaded    = 1'b0;
        cur_item  = 0;
        load_golden();
        loaded = 1'b1;
        wait (g_resetn);
        assert (pc == RESET_PC) else report_mismatch("pc after reset", RESET_PC, pc);
        foreach (item_q[i]) begin
            run_item(i);
        end
        if (u_frv_wb_subsystem.u_writeback.u_wb_asserts.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run("handshake assertion failed");
        end
    end

    // Watchdog, 4 cycles per item plus margin for reset
    initial begin
        int limit;
        wait (loaded);
        limit = item_q.size() * 4 + 50;
        repeat (limit) @(posedge g_clk);
        fail_run("watchdog expired before all items retired");
    end

endmodule

`default_nettype wire

/* tb/wb_golden.txt */
# kind rd opr_a opr_b pc next_pc uop fu trap instr | exp_wen exp_wdata exp_pc rb_idx rb_val
# all hex; fu 0 alu 1 mul 2 lsu 3 cfu 4 csr; exp_wdata checked only when exp_wen is 1
alu    01 11111111 00000000 00000100 00000104 00 0 0 002081b3 1 11111111 00000100 01 11111111
mul    02 deadbeef 00000000 00000104 00000108 00 1 0 02208133 1 deadbeef 00000100 02 deadbeef
load   03 cafef00d 00000000 00000108 0000010c 08 2 0 0000a183 1 cafef00d 00000100 03 cafef00d
store  04 12345678 00000000 0000010c 00000110 00 2 0 0030a023 0 00000000 00000100 04 00000000
alu    00 ffffffff 00000000 00000110 00000114 00 0 0 fff00013 1 ffffffff 00000100 00 00000000
csrw   00 a5a5a5a5 00000340 00000114 00000118 08 4 0 34029073 0 00000000 00000100 01 11111111
csrr   05 00000000 00000340 00000118 0000011c 10 4 0 340022f3 1 a5a5a5a5 00000100 05 a5a5a5a5
csrs   06 0000ff00 00000340 0000011c 00000120 14 4 0 3402a373 1 a5a5a5a5 00000100 06 a5a5a5a5
csrc   07 a5000000 00000340 00000120 00000124 12 4 0 3402b3f3 1 a5a5ffa5 00000100 07 a5a5ffa5
csrr   08 00000000 00000340 00000124 00000128 10 4 0 34002473 1 00a5ffa5 00000100 08 00a5ffa5
beq    00 00000200 00000000 00000128 0000012c 01 3 0 0c208063 0 00000000 00000200 00 00000000
bne    00 00000300 00000000 00000200 00000204 02 3 0 10209063 0 00000000 00000200 00 00000000
jal    09 00000400 00000000 00000204 00000208 03 3 0 1fc004ef 1 00000208 00000400 09 00000208
jalr   0a 00000500 00000000 00000400 00000404 04 3 0 10048567 1 00000404 00000500 0a 00000404
ecall  0b 00000000 00000000 00000500 00000504 06 3 0 00000073 0 00000000 00000080 0b 00000000
csrr   0c 00000000 00000341 00000080 00000084 10 4 0 34102673 1 00000500 00000080 0c 00000500
csrr   0d 00000000 00000342 00000084 00000088 10 4 0 342026f3 1 0000000b 00000080 0d 0000000b
ebreak 0e 00000000 00000000 00000088 0000008c 07 3 0 00100073 0 00000000 00000080 0e 00000000
csrr   0f 00000000 00000341 00000080 00000084 10 4 0 341027f3 1 00000088 00000080 0f 00000088
csrr   10 00000000 00000342 00000084 00000088 10 4 0 34202873 1 00000003 00000080 10 00000003
trap   11 77777777 00000000 00000090 00000094 00 0 1 00f00893 0 00000000 00000080 11 00000000
csrr   12 00000000 00000341 00000080 00000084 10 4 0 34102973 1 00000090 00000080 12 00000090
csrr   13 00000000 00000342 00000084 00000088 10 4 0 342029f3 1 8000000b 00000080 13 8000000b
csrw   00 00000600 00000341 00000088 0000008c 08 4 0 34151073 0 00000000 00000080 14 00000000
mret   00 00000000 00000000 0000008c 00000090 05 3 0 30200073 0 00000000 00000600 00 00000000
csrr   14 00000000 00000341 00000600 00000604 10 4 0 34102a73 1 00000600 00000600 14 00000600
csrr   15 00000000 00000305 00000604 00000608 10 4 0 30502af3 1 00000080 00000600 15 00000080
mul    01 0f0f0f0f 00000000 00000608 0000060c 00 1 0 021080b3 1 0f0f0f0f 00000600 01 0f0f0f0f

/* vlog.f */
source/frv_pkg.sv
source/frv_gpr_file.sv
source/frv_csr_file.sv
source/frv_pc_redirect.sv
source/frv_writeback.sv
source/frv_wb_subsystem.sv
tb/tb_clock.sv
tb/wb_asserts.sv
tb/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the writeback testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f vlog.f \
    -Mdir obj_dir -o sim_tb || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }
